// ==== exu_pkg.sv ====
// execute unit shared definitions
package exu_pkg;

  localparam int XLEN       = 64;
  localparam int ILEN       = 32;
  localparam int PIPE_DEPTH = 3;

  // encodings shared by decode and the alu
  typedef enum logic [4:0] {
    alu_add      = 5'd0,
    alu_sub      = 5'd1,
    alu_slt      = 5'd2,
    alu_sltu     = 5'd3,
    alu_xor      = 5'd4,
    alu_and      = 5'd5,
    alu_or       = 5'd6,
    alu_sll      = 5'd7,
    alu_srl      = 5'd8,
    alu_sra      = 5'd9,
    alu_mul      = 5'd10,
    alu_div      = 5'd11,
    alu_divu     = 5'd12,
    alu_rem      = 5'd13,
    alu_remu     = 5'd14,
    alu_copy_imm = 5'd15,
    alu_csr_pass = 5'd16
  } alu_op_e;

  typedef enum logic {a_rs1 = 1'b0, a_pc = 1'b1} a_src_e;

  typedef enum logic [1:0] {b_rs2 = 2'd0, b_imm = 2'd1, b_four = 2'd2} b_src_e;

  // lt and ge take signedness from the alu op
  typedef enum logic [2:0] {
    br_none = 3'd0, br_jal = 3'd1, br_jalr = 3'd2,
    br_eq   = 3'd4, br_ne  = 3'd5, br_lt   = 3'd6, br_ge = 3'd7
  } branch_e;

  typedef enum logic [2:0] {
    mem_lb = 3'd0, mem_lbu = 3'd1, mem_lh  = 3'd2, mem_lhu = 3'd3,
    mem_lw = 3'd4, mem_lwu = 3'd5, mem_ld  = 3'd6
  } mem_op_e;

  typedef enum logic [1:0] {
    ex_normal = 2'd0, ex_ebreak = 2'd2, ex_invalid = 2'd3
  } ex_ctl_e;

  typedef enum logic [6:0] {
    op_load   = 7'b0000011, op_imm    = 7'b0010011, op_auipc = 7'b0010111,
    op_imm_32 = 7'b0011011, op_op     = 7'b0110011, op_lui   = 7'b0110111,
    op_op_32  = 7'b0111011, op_branch = 7'b1100011, op_jalr  = 7'b1100111,
    op_jal    = 7'b1101111, op_system = 7'b1110011
  } opcode_e;

endpackage

// ==== exu_pipe_if.sv ====
// execute pipeline stage links
`timescale 1ns/100ps

interface dec_ex_if;
  import exu_pkg::*;

  logic            valid;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] rdata;
  alu_op_e         alu_op;
  a_src_e          a_src;
  b_src_e          b_src;
  logic            word;
  branch_e         branch;
  mem_op_e         mem_op;
  logic            mem_to_reg;
  logic            sel_csr;
  ex_ctl_e         ex_ctl;

  modport src (output valid, pc, rs1, rs2, imm, rdata, alu_op, a_src, b_src, word,
               branch, mem_op, mem_to_reg, sel_csr, ex_ctl);
  modport dst (input valid, pc, rs1, rs2, imm, rdata, alu_op, a_src, b_src, word,
               branch, mem_op, mem_to_reg, sel_csr, ex_ctl);
endinterface

interface ex_wb_if;
  import exu_pkg::*;

  logic            valid;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] nextpc;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] rdata;
  mem_op_e         mem_op;
  logic            mem_to_reg;
  logic            sel_csr;
  ex_ctl_e         ex_ctl;

  modport src (output valid, alu_result, nextpc, rs2, rdata, mem_op, mem_to_reg, sel_csr, ex_ctl);
  modport dst (input valid, alu_result, nextpc, rs2, rdata, mem_op, mem_to_reg, sel_csr, ex_ctl);
endinterface

// ==== exu_alu.sv ====
// rv64im arithmetic unit
`timescale 1ns/100ps

module exu_alu (
  input  exu_pkg::alu_op_e         i_op,
  input  logic                     i_word,
  input  logic [exu_pkg::XLEN-1:0] i_src_a,
  input  logic [exu_pkg::XLEN-1:0] i_src_b,
  input  logic [exu_pkg::XLEN-1:0] i_imm,
  output logic [exu_pkg::XLEN-1:0] o_result,
  output logic                     o_zero,
  output logic                     o_less
);
  import exu_pkg::*;

  logic [XLEN-1:0] a_sx, b_sx, a_zx, b_zx;
  logic [XLEN-1:0] diff;
  logic            borrow;
  logic            lt_s;
  logic [5:0]      shamt;
  logic            div_zero;
  logic            div_ovf;
  logic [XLEN-1:0] quot_raw, rem_raw;
  logic [XLEN-1:0] quot_s, rem_s, quot_u, rem_u;
  logic [XLEN-1:0] res;

  // word mode keeps the low half, extended as each op needs
  assign a_sx = i_word ? {{32{i_src_a[31]}}, i_src_a[31:0]} : i_src_a;
  assign b_sx = i_word ? {{32{i_src_b[31]}}, i_src_b[31:0]} : i_src_b;
  assign a_zx = i_word ? {32'b0, i_src_a[31:0]} : i_src_a;
  assign b_zx = i_word ? {32'b0, i_src_b[31:0]} : i_src_b;

  // borrow out of the subtract is the unsigned less-than
  assign {borrow, diff} = {1'b0, a_sx} - {1'b0, b_sx};
  assign lt_s   = (a_sx[XLEN-1] != b_sx[XLEN-1]) ? a_sx[XLEN-1] : diff[XLEN-1];
  assign o_zero = ~|diff;
  assign o_less = (i_op == alu_sltu) ? borrow : lt_s;

  assign shamt = i_word ? {1'b0, b_sx[4:0]} : b_sx[5:0];

  // riscv rules for x/0 and min/-1
  assign div_zero = ~|b_zx;
  assign div_ovf  = (a_sx == {1'b1, {(XLEN-1){1'b0}}}) && (&b_sx);
  assign quot_raw = $signed(a_sx) / $signed(b_sx);
  assign rem_raw  = $signed(a_sx) % $signed(b_sx);
  assign quot_s   = div_zero ? '1 : (div_ovf ? a_sx : quot_raw);
  assign rem_s    = div_zero ? a_sx : (div_ovf ? '0 : rem_raw);
  assign quot_u   = div_zero ? '1 : a_zx / b_zx;
  assign rem_u    = div_zero ? a_zx : a_zx % b_zx;

  always_comb begin
    case (i_op)
      alu_sub:      res = diff;
      alu_slt:      res = {{(XLEN-1){1'b0}}, lt_s};
      alu_sltu:     res = {{(XLEN-1){1'b0}}, borrow};
      alu_xor:      res = a_sx ^ b_sx;
      alu_and:      res = a_sx & b_sx;
      alu_or:       res = a_sx | b_sx;
      alu_sll:      res = a_sx << shamt;
      alu_srl:      res = a_zx >> shamt;
      alu_sra:      res = $signed(a_sx) >>> shamt;
      alu_mul:      res = a_sx * b_sx;
      alu_div:      res = quot_s;
      alu_divu:     res = quot_u;
      alu_rem:      res = rem_s;
      alu_remu:     res = rem_u;
      alu_copy_imm: res = i_imm;
      alu_csr_pass: res = i_src_a;
      default:      res = a_sx + b_sx;
    endcase
  end

  assign o_result = i_word ? {{32{res[31]}}, res[31:0]} : res;

endmodule

// ==== exu_decode.sv ====
// instruction decode stage
`timescale 1ns/100ps

module exu_decode (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_valid,
  input  logic [exu_pkg::ILEN-1:0] i_inst,
  input  logic [exu_pkg::XLEN-1:0] i_pc,
  input  logic [exu_pkg::XLEN-1:0] i_rs1,
  input  logic [exu_pkg::XLEN-1:0] i_rs2,
  input  logic [exu_pkg::XLEN-1:0] i_rdata,
  dec_ex_if.src                    o_dec
);
  import exu_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_b, imm_u, imm_j, imm_d;
  alu_op_e         alu_d;
  a_src_e          a_d;
  b_src_e          b_d;
  logic            word_d;
  branch_e         br_d;
  mem_op_e         mem_d;
  logic            m2r_d;
  logic            csr_d;
  ex_ctl_e         ctl_d;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    alu_d  = alu_add;
    a_d    = a_rs1;
    b_d    = b_rs2;
    word_d = 1'b0;
    br_d   = br_none;
    mem_d  = mem_lb;
    m2r_d  = 1'b0;
    csr_d  = 1'b0;
    ctl_d  = ex_normal;
    imm_d  = imm_i;
    case (opcode)
      op_lui: begin
        alu_d = alu_copy_imm;
        b_d   = b_imm;
        imm_d = imm_u;
      end
      op_auipc: begin
        a_d   = a_pc;
        b_d   = b_imm;
        imm_d = imm_u;
      end
      // link value is pc + 4, target comes from the next-pc adder
      op_jal: begin
        a_d   = a_pc;
        b_d   = b_four;
        br_d  = br_jal;
        imm_d = imm_j;
      end
      op_jalr: begin
        a_d  = a_pc;
        b_d  = b_four;
        br_d = br_jalr;
        if (funct3 != 3'b000) ctl_d = ex_invalid;
      end
      op_branch: begin
        imm_d = imm_b;
        case (funct3)
          3'b000: begin alu_d = alu_sub;  br_d = br_eq; end
          3'b001: begin alu_d = alu_sub;  br_d = br_ne; end
          3'b100: begin alu_d = alu_slt;  br_d = br_lt; end
          3'b101: begin alu_d = alu_slt;  br_d = br_ge; end
          3'b110: begin alu_d = alu_sltu; br_d = br_lt; end
          3'b111: begin alu_d = alu_sltu; br_d = br_ge; end
          default: ctl_d = ex_invalid;
        endcase
      end
      op_load: begin
        b_d   = b_imm;
        m2r_d = 1'b1;
        case (funct3)
          3'b000: mem_d = mem_lb;
          3'b001: mem_d = mem_lh;
          3'b010: mem_d = mem_lw;
          3'b011: mem_d = mem_ld;
          3'b100: mem_d = mem_lbu;
          3'b101: mem_d = mem_lhu;
          3'b110: mem_d = mem_lwu;
          default: ctl_d = ex_invalid;
        endcase
      end
      op_imm, op_imm_32: begin
        b_d    = b_imm;
        word_d = (opcode == op_imm_32);
        case (funct3)
          3'b000: alu_d = alu_add;
          3'b010: alu_d = word_d ? alu_add : alu_slt;
          3'b011: alu_d = word_d ? alu_add : alu_sltu;
          3'b100: alu_d = word_d ? alu_add : alu_xor;
          3'b110: alu_d = word_d ? alu_add : alu_or;
          3'b111: alu_d = word_d ? alu_add : alu_and;
          3'b001: alu_d = alu_sll;
          default: alu_d = i_inst[30] ? alu_sra : alu_srl;
        endcase
        // rv64 shamt is 6 bits wide, word shifts only 5
        if (word_d && (funct3 inside {3'b010, 3'b011, 3'b100, 3'b110, 3'b111}))
          ctl_d = ex_invalid;
        if (funct3 == 3'b001 && (i_inst[31:26] != 6'b0 || (word_d && i_inst[25])))
          ctl_d = ex_invalid;
        if (funct3 == 3'b101 && ({i_inst[31], i_inst[29:26]} != 5'b0 || (word_d && i_inst[25])))
          ctl_d = ex_invalid;
      end
      op_op, op_op_32: begin
        word_d = (opcode == op_op_32);
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_d = alu_add;
          {7'b0100000, 3'b000}: alu_d = alu_sub;
          {7'b0000000, 3'b001}: alu_d = alu_sll;
          {7'b0000000, 3'b101}: alu_d = alu_srl;
          {7'b0100000, 3'b101}: alu_d = alu_sra;
          {7'b0000001, 3'b000}: alu_d = alu_mul;
          {7'b0000001, 3'b100}: alu_d = alu_div;
          {7'b0000001, 3'b101}: alu_d = alu_divu;
          {7'b0000001, 3'b110}: alu_d = alu_rem;
          {7'b0000001, 3'b111}: alu_d = alu_remu;
          {7'b0000000, 3'b010}: alu_d = alu_slt;
          {7'b0000000, 3'b011}: alu_d = alu_sltu;
          {7'b0000000, 3'b100}: alu_d = alu_xor;
          {7'b0000000, 3'b110}: alu_d = alu_or;
          {7'b0000000, 3'b111}: alu_d = alu_and;
          default: ctl_d = ex_invalid;
        endcase
        // no word form of compare or logic ops
        if (word_d && (alu_d inside {alu_slt, alu_sltu, alu_xor, alu_or, alu_and}))
          ctl_d = ex_invalid;
      end
      op_system: begin
        if (funct3 == 3'b001) begin
          alu_d = alu_csr_pass;
          csr_d = 1'b1;
        end else if (i_inst == 32'h0010_0073) begin
          ctl_d = ex_ebreak;
        end else begin
          ctl_d = ex_invalid;
        end
      end
      default: ctl_d = ex_invalid;
    endcase
    if (ctl_d == ex_invalid) begin
      alu_d  = alu_add;
      word_d = 1'b0;
      br_d   = br_none;
      m2r_d  = 1'b0;
      csr_d  = 1'b0;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_dec.valid      <= 1'b0;
      o_dec.pc         <= '0;
      o_dec.rs1        <= '0;
      o_dec.rs2        <= '0;
      o_dec.imm        <= '0;
      o_dec.rdata      <= '0;
      o_dec.alu_op     <= alu_add;
      o_dec.a_src      <= a_rs1;
      o_dec.b_src      <= b_rs2;
      o_dec.word       <= 1'b0;
      o_dec.branch     <= br_none;
      o_dec.mem_op     <= mem_lb;
      o_dec.mem_to_reg <= 1'b0;
      o_dec.sel_csr    <= 1'b0;
      o_dec.ex_ctl     <= ex_normal;
    end else begin
      o_dec.valid <= i_valid;
      if (i_valid) begin
        o_dec.pc         <= i_pc;
        o_dec.rs1        <= i_rs1;
        o_dec.rs2        <= i_rs2;
        o_dec.imm        <= imm_d;
        o_dec.rdata      <= i_rdata;
        o_dec.alu_op     <= alu_d;
        o_dec.a_src      <= a_d;
        o_dec.b_src      <= b_d;
        o_dec.word       <= word_d;
        o_dec.branch     <= br_d;
        o_dec.mem_op     <= mem_d;
        o_dec.mem_to_reg <= m2r_d;
        o_dec.sel_csr    <= csr_d;
        o_dec.ex_ctl     <= ctl_d;
      end
    end
  end

endmodule

// ==== exu_execute.sv ====
// execute stage
`timescale 1ns/100ps

module exu_execute (
  input  logic  i_clk,
  input  logic  i_arst_n,
  dec_ex_if.dst i_dec,
  ex_wb_if.src  o_ex
);
  import exu_pkg::*;

  logic [XLEN-1:0] src_a, src_b;
  logic [XLEN-1:0] alu_result;
  logic            zero, less;
  logic            taken;
  logic [XLEN-1:0] pc_sum, nextpc;

  assign src_a = (i_dec.a_src == a_pc) ? i_dec.pc : i_dec.rs1;

  always_comb begin
    case (i_dec.b_src)
      b_imm:   src_b = i_dec.imm;
      b_four:  src_b = XLEN'(4);
      default: src_b = i_dec.rs2;
    endcase
  end

  exu_alu u_alu (
    .i_op     (i_dec.alu_op),
    .i_word   (i_dec.word),
    .i_src_a  (src_a),
    .i_src_b  (src_b),
    .i_imm    (i_dec.imm),
    .o_result (alu_result),
    .o_zero   (zero),
    .o_less   (less)
  );

  always_comb begin
    case (i_dec.branch)
      br_jal, br_jalr: taken = 1'b1;
      br_eq:           taken = zero;
      br_ne:           taken = ~zero;
      br_lt:           taken = less;
      br_ge:           taken = ~less;
      default:         taken = 1'b0;
    endcase
  end

  // jalr jumps relative to rs1 and drops bit 0
  assign pc_sum = ((i_dec.branch == br_jalr) ? i_dec.rs1 : i_dec.pc) +
                  (taken ? i_dec.imm : XLEN'(4));
  assign nextpc = (i_dec.branch == br_jalr) ? {pc_sum[XLEN-1:1], 1'b0} : pc_sum;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ex.valid      <= 1'b0;
      o_ex.alu_result <= '0;
      o_ex.nextpc     <= '0;
      o_ex.rs2        <= '0;
      o_ex.rdata      <= '0;
      o_ex.mem_op     <= mem_lb;
      o_ex.mem_to_reg <= 1'b0;
      o_ex.sel_csr    <= 1'b0;
      o_ex.ex_ctl     <= ex_normal;
    end else begin
      o_ex.valid <= i_dec.valid;
      if (i_dec.valid) begin
        o_ex.alu_result <= alu_result;
        o_ex.nextpc     <= nextpc;
        o_ex.rs2        <= i_dec.rs2;
        o_ex.rdata      <= i_dec.rdata;
        o_ex.mem_op     <= i_dec.mem_op;
        o_ex.mem_to_reg <= i_dec.mem_to_reg;
        o_ex.sel_csr    <= i_dec.sel_csr;
        o_ex.ex_ctl     <= i_dec.ex_ctl;
      end
    end
  end

endmodule

// ==== exu_writeback.sv ====
// writeback stage
`timescale 1ns/100ps

module exu_writeback (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  ex_wb_if.dst                     i_ex,
  output logic                     o_valid,
  output logic [exu_pkg::XLEN-1:0] o_result,
  output logic [exu_pkg::XLEN-1:0] o_nextpc,
  output logic [exu_pkg::XLEN-1:0] o_busw,
  output logic                     o_halt,
  output logic                     o_abort
);
  import exu_pkg::*;

  logic [XLEN-1:0] load_ext;
  logic [XLEN-1:0] busw;

  always_comb begin
    case (i_ex.mem_op)
      mem_lb:  load_ext = {{(XLEN-8){i_ex.rdata[7]}}, i_ex.rdata[7:0]};
      mem_lbu: load_ext = {{(XLEN-8){1'b0}}, i_ex.rdata[7:0]};
      mem_lh:  load_ext = {{(XLEN-16){i_ex.rdata[15]}}, i_ex.rdata[15:0]};
      mem_lhu: load_ext = {{(XLEN-16){1'b0}}, i_ex.rdata[15:0]};
      mem_lw:  load_ext = {{(XLEN-32){i_ex.rdata[31]}}, i_ex.rdata[31:0]};
      mem_lwu: load_ext = {{(XLEN-32){1'b0}}, i_ex.rdata[31:0]};
      default: load_ext = i_ex.rdata;
    endcase
  end

  // csrrw writes the old csr value, carried in rs2
  assign busw = i_ex.mem_to_reg ? load_ext : (i_ex.sel_csr ? i_ex.rs2 : i_ex.alu_result);

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid  <= 1'b0;
      o_result <= '0;
      o_nextpc <= '0;
      o_busw   <= '0;
      o_halt   <= 1'b0;
      o_abort  <= 1'b0;
    end else begin
      o_valid <= i_ex.valid;
      o_halt  <= i_ex.valid && (i_ex.ex_ctl == ex_ebreak);
      o_abort <= i_ex.valid && (i_ex.ex_ctl == ex_invalid);
      if (i_ex.valid) begin
        o_result <= i_ex.alu_result;
        o_nextpc <= i_ex.nextpc;
        o_busw   <= busw;
      end
    end
  end

endmodule

// ==== exu_top.sv ====
// pipelined execute unit
`timescale 1ns/100ps

module exu_top (
  input  logic                     i_clk,
  input  logic                     i_arst_n,
  input  logic                     i_valid,
  input  logic [exu_pkg::ILEN-1:0] i_inst,
  input  logic [exu_pkg::XLEN-1:0] i_pc,
  input  logic [exu_pkg::XLEN-1:0] i_rs1,
  input  logic [exu_pkg::XLEN-1:0] i_rs2,
  input  logic [exu_pkg::XLEN-1:0] i_rdata,
  output logic                     o_valid,
  output logic [exu_pkg::XLEN-1:0] o_result,
  output logic [exu_pkg::XLEN-1:0] o_nextpc,
  output logic [exu_pkg::XLEN-1:0] o_busw,
  output logic                     o_halt,
  output logic                     o_abort
);

  dec_ex_if u_dec_ex ();
  ex_wb_if  u_ex_wb ();

  exu_decode u_decode (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_valid),
    .i_inst   (i_inst),
    .i_pc     (i_pc),
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .i_rdata  (i_rdata),
    .o_dec    (u_dec_ex.src)
  );

  exu_execute u_execute (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_dec    (u_dec_ex.dst),
    .o_ex     (u_ex_wb.src)
  );

  exu_writeback u_writeback (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ex     (u_ex_wb.dst),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_nextpc (o_nextpc),
    .o_busw   (o_busw),
    .o_halt   (o_halt),
    .o_abort  (o_abort)
  );

endmodule

// ==== tb_exu_assert.sv ====
// execute unit timing checks
`timescale 1ns/100ps

module exu_assert (
  input logic i_clk,
  input logic i_arst_n,
  input logic i_valid,
  input logic o_valid,
  input logic o_halt,
  input logic o_abort
);
  import exu_pkg::*;

  // no stalls, so valid just walks through the stages
  valid_latency: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_valid == $past(i_valid, PIPE_DEPTH))
    else $error("o_valid does not follow i_valid by the pipeline depth");

  flags_with_valid: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (o_halt || o_abort) |-> o_valid)
    else $error("o_halt or o_abort high without o_valid");

  flags_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    !(o_halt && o_abort))
    else $error("o_halt and o_abort high together");

endmodule

bind exu_top exu_assert u_assert (
  .i_clk    (i_clk),
  .i_arst_n (i_arst_n),
  .i_valid  (i_valid),
  .o_valid  (o_valid),
  .o_halt   (o_halt),
  .o_abort  (o_abort)
);

// ==== tb_exu.sv ====
// execute unit testbench
`timescale 1ns/100ps

module tb_exu;
  import exu_pkg::*;

  localparam int RAND_ITEMS  = 40;
  localparam int DRAIN_LIMIT = 20;
  localparam logic [XLEN-1:0] PC0  = 64'h1000;
  localparam logic [XLEN-1:0] NPC  = 64'h1004;
  localparam logic [XLEN-1:0] TGT  = 64'h1010;
  localparam logic [XLEN-1:0] MIN  = 64'h8000_0000_0000_0000;
  localparam logic [XLEN-1:0] M20  = 64'hFFFF_FFFF_FFFF_FFEC;
  localparam logic [XLEN-1:0] LDAT = 64'h1234_5678_8765_8281;

  typedef struct packed {
    logic [ILEN-1:0] inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] nextpc;
    logic [XLEN-1:0] busw;
    logic            halt;
    logic            abort;
    logic [31:0]     cyc;
  } vec_t;

  logic            i_clk;
  logic            i_arst_n;
  logic            i_valid;
  logic [ILEN-1:0] i_inst;
  logic [XLEN-1:0] i_pc;
  logic [XLEN-1:0] i_rs1;
  logic [XLEN-1:0] i_rs2;
  logic [XLEN-1:0] i_rdata;
  logic            o_valid;
  logic [XLEN-1:0] o_result;
  logic [XLEN-1:0] o_nextpc;
  logic [XLEN-1:0] o_busw;
  logic            o_halt;
  logic            o_abort;

  vec_t            table_q[$];
  vec_t            expect_q[$];
  logic [XLEN-1:0] lcg_state;
  int              cyc;
  int              value_errs;
  int              other_errs;

  exu_top UUT (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_valid),
    .i_inst   (i_inst),
    .i_pc     (i_pc),
    .i_rs1    (i_rs1),
    .i_rs2    (i_rs2),
    .i_rdata  (i_rdata),
    .o_valid  (o_valid),
    .o_result (o_result),
    .o_nextpc (o_nextpc),
    .o_busw   (o_busw),
    .o_halt   (o_halt),
    .o_abort  (o_abort)
  );

  initial i_clk = 1'b0;
  always #5 i_clk = ~i_clk;

  // count of rising edges already past
  always @(posedge i_clk) cyc <= cyc + 1;

  function automatic logic [XLEN-1:0] lcg_next();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state;
  endfunction

  task automatic add_vec(input logic [ILEN-1:0] inst, input logic [XLEN-1:0] pc, rs1, rs2,
                         input logic [XLEN-1:0] rdata, result, nextpc, busw,
                         input logic halt, abort);
    vec_t v;
    v = '0;
    v.inst   = inst;
    v.pc     = pc;
    v.rs1    = rs1;
    v.rs2    = rs2;
    v.rdata  = rdata;
    v.result = result;
    v.nextpc = nextpc;
    v.busw   = busw;
    v.halt   = halt;
    v.abort  = abort;
    table_q.push_back(v);
  endtask

  task automatic build_table();
    // alu ops, shifts and word forms
    add_vec(32'h003100B3, PC0, 64'd5, 64'd7, '0, 64'd12, NPC, 64'd12, 1'b0, 1'b0);
    add_vec(32'h403100B3, PC0, 64'd5, 64'd7, '0,
            64'hFFFF_FFFF_FFFF_FFFE, NPC, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0, 1'b0);
    add_vec(32'h003120B3, PC0, '1, 64'd1, '0, 64'd1, NPC, 64'd1, 1'b0, 1'b0);
    add_vec(32'h003130B3, PC0, '1, 64'd1, '0, 64'd0, NPC, 64'd0, 1'b0, 1'b0);
    add_vec(32'h003110B3, PC0, 64'd1, 64'd63, '0, MIN, NPC, MIN, 1'b0, 1'b0);
    add_vec(32'h003150B3, PC0, MIN, 64'd4, '0,
            64'h0800_0000_0000_0000, NPC, 64'h0800_0000_0000_0000, 1'b0, 1'b0);
    add_vec(32'h403150B3, PC0, MIN, 64'd4, '0,
            64'hF800_0000_0000_0000, NPC, 64'hF800_0000_0000_0000, 1'b0, 1'b0);
    add_vec(32'h003100BB, PC0, 64'h7FFF_FFFF, 64'd1, '0,
            64'hFFFF_FFFF_8000_0000, NPC, 64'hFFFF_FFFF_8000_0000, 1'b0, 1'b0);
    add_vec(32'h403150BB, PC0, 64'h8000_0000, 64'd4, '0,
            64'hFFFF_FFFF_F800_0000, NPC, 64'hFFFF_FFFF_F800_0000, 1'b0, 1'b0);
    add_vec(32'hFFF10093, PC0, '0, '0, '0, '1, NPC, '1, 1'b0, 1'b0);
    // m extension with x/0 and min/-1
    add_vec(32'h023100B3, PC0, 64'hFFFF_FFFF_FFFF_FFFD, 64'd7, '0,
            64'hFFFF_FFFF_FFFF_FFEB, NPC, 64'hFFFF_FFFF_FFFF_FFEB, 1'b0, 1'b0);
    add_vec(32'h023140B3, PC0, M20, 64'd3, '0,
            64'hFFFF_FFFF_FFFF_FFFA, NPC, 64'hFFFF_FFFF_FFFF_FFFA, 1'b0, 1'b0);
    add_vec(32'h023160B3, PC0, M20, 64'd3, '0,
            64'hFFFF_FFFF_FFFF_FFFE, NPC, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0, 1'b0);
    add_vec(32'h023150B3, PC0, '1, 64'd2, '0,
            64'h7FFF_FFFF_FFFF_FFFF, NPC, 64'h7FFF_FFFF_FFFF_FFFF, 1'b0, 1'b0);
    add_vec(32'h023170B3, PC0, '1, 64'd2, '0, 64'd1, NPC, 64'd1, 1'b0, 1'b0);
    add_vec(32'h023140B3, PC0, 64'd100, '0, '0, '1, NPC, '1, 1'b0, 1'b0);
    add_vec(32'h023150B3, PC0, 64'd100, '0, '0, '1, NPC, '1, 1'b0, 1'b0);
    add_vec(32'h023160B3, PC0, 64'd100, '0, '0, 64'd100, NPC, 64'd100, 1'b0, 1'b0);
    add_vec(32'h023170B3, PC0, 64'd100, '0, '0, 64'd100, NPC, 64'd100, 1'b0, 1'b0);
    add_vec(32'h023140B3, PC0, MIN, '1, '0, MIN, NPC, MIN, 1'b0, 1'b0);
    add_vec(32'h023160B3, PC0, MIN, '1, '0, '0, NPC, '0, 1'b0, 1'b0);
    add_vec(32'h023140BB, PC0, 64'h8000_0000, '1, '0,
            64'hFFFF_FFFF_8000_0000, NPC, 64'hFFFF_FFFF_8000_0000, 1'b0, 1'b0);
    // branches jump by 16 when taken
    add_vec(32'h00310863, PC0, 64'd5, 64'd5, '0, '0, TGT, '0, 1'b0, 1'b0);
    add_vec(32'h00310863, PC0, 64'd5, 64'd7, '0,
            64'hFFFF_FFFF_FFFF_FFFE, NPC, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0, 1'b0);
    add_vec(32'h00311863, PC0, 64'd5, 64'd7, '0,
            64'hFFFF_FFFF_FFFF_FFFE, TGT, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0, 1'b0);
    add_vec(32'h00314863, PC0, '1, 64'd1, '0, 64'd1, TGT, 64'd1, 1'b0, 1'b0);
    add_vec(32'h00315863, PC0, '1, 64'd1, '0, 64'd1, NPC, 64'd1, 1'b0, 1'b0);
    add_vec(32'h00316863, PC0, '1, 64'd1, '0, 64'd0, NPC, 64'd0, 1'b0, 1'b0);
    add_vec(32'h00317863, PC0, '1, 64'd1, '0, 64'd0, TGT, 64'd0, 1'b0, 1'b0);
    add_vec(32'h020000EF, PC0, '0, '0, '0, NPC, 64'h1020, NPC, 1'b0, 1'b0);
    add_vec(32'h005100E7, PC0, 64'h2000, '0, '0, NPC, 64'h2004, NPC, 1'b0, 1'b0);
    add_vec(32'h800000B7, PC0, '0, '0, '0,
            64'hFFFF_FFFF_8000_0000, NPC, 64'hFFFF_FFFF_8000_0000, 1'b0, 1'b0);
    add_vec(32'h00001097, PC0, '0, '0, '0, 64'h2000, NPC, 64'h2000, 1'b0, 1'b0);
    // loads of every width
    add_vec(32'h00010083, PC0, 64'h100, '0, LDAT,
            64'h100, NPC, 64'hFFFF_FFFF_FFFF_FF81, 1'b0, 1'b0);
    add_vec(32'h00014083, PC0, 64'h100, '0, LDAT, 64'h100, NPC, 64'h81, 1'b0, 1'b0);
    add_vec(32'h00011083, PC0, 64'h100, '0, LDAT,
            64'h100, NPC, 64'hFFFF_FFFF_FFFF_8281, 1'b0, 1'b0);
    add_vec(32'h00015083, PC0, 64'h100, '0, LDAT, 64'h100, NPC, 64'h8281, 1'b0, 1'b0);
    add_vec(32'h00012083, PC0, 64'h100, '0, LDAT,
            64'h100, NPC, 64'hFFFF_FFFF_8765_8281, 1'b0, 1'b0);
    add_vec(32'h00016083, PC0, 64'h100, '0, LDAT, 64'h100, NPC, 64'h8765_8281, 1'b0, 1'b0);
    add_vec(32'h00013083, PC0, 64'h100, '0, LDAT, 64'h100, NPC, LDAT, 1'b0, 1'b0);
    // csrrw, ebreak, undefined opcode
    add_vec(32'h300110F3, PC0, 64'hAAAA, 64'h5555, '0, 64'hAAAA, NPC, 64'h5555, 1'b0, 1'b0);
    add_vec(32'h00100073, PC0, '0, '0, '0, '0, NPC, '0, 1'b1, 1'b0);
    add_vec(32'hFFFFFFFF, PC0, '0, '0, '0, '0, NPC, '0, 1'b0, 1'b1);
  endtask

  task automatic drive_item(input vec_t v);
    vec_t rec;
    @(negedge i_clk);
    i_valid = 1'b1;
    i_inst  = v.inst;
    i_pc    = v.pc;
    i_rs1   = v.rs1;
    i_rs2   = v.rs2;
    i_rdata = v.rdata;
    rec     = v;
    rec.cyc = cyc;
    expect_q.push_back(rec);
  endtask

  task automatic drive_random(input int idx);
    vec_t            v;
    logic [XLEN-1:0] sum;
    v      = '0;
    v.rs1  = lcg_next();
    v.rs2  = lcg_next();
    v.pc   = 64'h4000 + XLEN'(idx * 4);
    sum    = v.rs1 + v.rs2;
    case (idx % 4)
      0: begin
        v.inst   = 32'h003100B3;
        v.result = sum;
      end
      1: begin
        v.inst   = 32'h403100B3;
        v.result = v.rs1 - v.rs2;
      end
      2: begin
        v.inst   = 32'h003140B3;
        v.result = v.rs1 ^ v.rs2;
      end
      default: begin
        v.inst   = 32'h003100BB;
        v.result = {{32{sum[31]}}, sum[31:0]};
      end
    endcase
    v.nextpc = v.pc + 64'd4;
    v.busw   = v.result;
    drive_item(v);
  endtask

  task automatic check_val(input string name, input logic [XLEN-1:0] exp_val,
                           input logic [XLEN-1:0] act_val);
    assert (act_val === exp_val) else begin
      $display("ERROR at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
      value_errs++;
    end
  endtask

  always @(posedge i_clk) begin : check_out
    vec_t exp_v;
    if (o_valid) begin
      if (expect_q.size() == 0) begin
        $display("o_valid was high at %0t with no item in flight", $time);
        other_errs++;
      end else begin
        exp_v = expect_q.pop_front();
        check_val("o_result", exp_v.result, o_result);
        check_val("o_nextpc", exp_v.nextpc, o_nextpc);
        check_val("o_busw", exp_v.busw, o_busw);
        check_val("o_halt", XLEN'(exp_v.halt), XLEN'(o_halt));
        check_val("o_abort", XLEN'(exp_v.abort), XLEN'(o_abort));
        assert (cyc - int'(exp_v.cyc) == PIPE_DEPTH) else begin
          $display("item with pc %h came out %0d cycles after its input",
                   exp_v.pc, cyc - int'(exp_v.cyc));
          other_errs++;
        end
      end
    end
  end

  initial begin
    int wait_cnt;
    i_arst_n   = 1'b0;
    i_valid    = 1'b0;
    i_inst     = '0;
    i_pc       = '0;
    i_rs1      = '0;
    i_rs2      = '0;
    i_rdata    = '0;
    cyc        = 0;
    value_errs = 0;
    other_errs = 0;
    lcg_state  = 64'd18150;
    build_table();
    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_arst_n = 1'b1;

    foreach (table_q[i]) drive_item(table_q[i]);
    for (int i = 0; i < RAND_ITEMS; i++) drive_random(i);
    @(negedge i_clk);
    i_valid = 1'b0;

    wait_cnt = 0;
    while (expect_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
      @(negedge i_clk);
      wait_cnt++;
    end
    if (expect_q.size() != 0) begin
      $display("timed out with %0d results still missing", expect_q.size());
      other_errs++;
    end
    // catch stray outputs after the last item
    repeat (PIPE_DEPTH + 1) @(negedge i_clk);

    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== src.f ====
exu_pkg.sv
exu_pipe_if.sv
exu_alu.sv
exu_decode.sv
exu_execute.sv
exu_writeback.sv
exu_top.sv
tb_exu_assert.sv
tb_exu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exu
FLIST     ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
